/* src/mem_stage_pkg.sv */
package mem_stage_pkg;

    ////////////////////////////////////////////////////////////
    // Load formatting and branch condition codes
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        LOAD_WORD   = 3'd0,
        LOAD_BYTE_S = 3'd1,
        LOAD_BYTE_U = 3'd2,
        LOAD_HALF_S = 3'd3,
        LOAD_HALF_U = 3'd4
    } load_sel_e;

    // Evaluated on lf (a < b) and zf (a == b)
    typedef enum logic [2:0] {
        COND_EQ = 3'd0,
        COND_NE = 3'd1,
        COND_LT = 3'd2,
        COND_GE = 3'd3,
        COND_GT = 3'd4,
        COND_LE = 3'd5
    } cond_e;

    ////////////////////////////////////////////////////////////
    // Stage records
    ////////////////////////////////////////////////////////////

    // Execute results entering the memory stage
    typedef struct packed {
        logic [31:0] pc_4;
        logic [31:0] alu_res;
        logic [31:0] store_data;
        logic        mem_r;
        logic        mem_w;
        logic [3:0]  mem_byte_en;
        logic        reg_w;
        logic [3:0]  reg_byte_en;
        logic [4:0]  rd_addr;
        load_sel_e   load_sel;
        logic        branch;
        logic        jmp;
        cond_e       condition;
        logic [31:0] target;
        logic        lf;
        logic        zf;
    } exmem_payload_t;

    // Writeback record
    typedef struct packed {
        logic [31:0] pc_4;
        logic [31:0] wb_data;
        logic        reg_w;
        logic [3:0]  reg_byte_en;
        logic [4:0]  rd_addr;
        logic        taken;
        logic [31:0] target;
    } memwb_payload_t;

    // Single RAM access at a byte address
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byte_en;
        logic        we;
    } mem_req_t;

endpackage

/* src/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic active;
    logic accept;

    // Stays closed while in reset, opens the cycle after
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    // Free slot, or the current entry leaves this cycle
    assign in_ready = active && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            // An accepted item under flush is dropped
            out_valid <= accept && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= in_data;
        end
    end

    // Held entry must not change while downstream stalls
    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> $stable(out_data)
    );

endmodule

/* src/mem_stage_unit.sv */
`timescale 1ns/1ps

module mem_stage_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  mem_stage_pkg::exmem_payload_t in_data,
    output logic                          req_valid,
    input  logic                          req_ready,
    output mem_stage_pkg::mem_req_t       req,
    input  logic                          rsp_valid,
    input  logic [31:0]                   rsp_data,
    output logic                          out_valid,
    input  logic                          out_ready,
    output mem_stage_pkg::memwb_payload_t out_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DONE
    } state_t;

    state_t      state;
    logic        is_mem;
    logic        cond_met;
    logic [31:0] rdata_q;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic [31:0] load_data;

    assign is_mem = in_data.mem_r || in_data.mem_w;

    ////////////////////////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (in_data.condition)
            mem_stage_pkg::COND_EQ: cond_met = in_data.zf;
            mem_stage_pkg::COND_NE: cond_met = !in_data.zf;
            mem_stage_pkg::COND_LT: cond_met = in_data.lf;
            mem_stage_pkg::COND_GE: cond_met = !in_data.lf;
            mem_stage_pkg::COND_GT: cond_met = !in_data.lf && !in_data.zf;
            mem_stage_pkg::COND_LE: cond_met = in_data.lf || in_data.zf;
            default:                cond_met = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Data access
    ////////////////////////////////////////////////////////////

    // Word aligned address with lanes picked by byte_en
    assign req.addr    = {in_data.alu_res[31:2], 2'b00};
    assign req.wdata   = in_data.store_data;
    assign req.byte_en = in_data.mem_byte_en;
    assign req.we      = in_data.mem_w;

    always_comb begin
        req_valid = 1'b0;
        in_ready  = 1'b0;
        out_valid = 1'b0;
        case (state)
            ST_IDLE: begin
                if (is_mem) begin
                    req_valid = in_valid;
                end else begin
                    out_valid = in_valid;
                    in_ready  = out_ready;
                end
            end
            ST_DONE: begin
                out_valid = 1'b1;
                in_ready  = out_ready;
            end
            default: begin
                // Request in flight
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (in_valid && is_mem && req_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rsp_valid) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (out_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Response word kept until the record is taken
    always_ff @(posedge clk) begin
        if (state == ST_WAIT && rsp_valid) begin
            rdata_q <= rsp_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Load formatting and writeback record
    ////////////////////////////////////////////////////////////

    assign load_byte = rdata_q[{in_data.alu_res[1:0], 3'b000} +: 8];
    assign load_half = in_data.alu_res[1] ? rdata_q[31:16] : rdata_q[15:0];

    always_comb begin
        case (in_data.load_sel)
            mem_stage_pkg::LOAD_BYTE_S: load_data = {{24{load_byte[7]}}, load_byte};
            mem_stage_pkg::LOAD_BYTE_U: load_data = {24'd0, load_byte};
            mem_stage_pkg::LOAD_HALF_S: load_data = {{16{load_half[15]}}, load_half};
            mem_stage_pkg::LOAD_HALF_U: load_data = {16'd0, load_half};
            default:                    load_data = rdata_q;
        endcase
    end

    always_comb begin
        out_data.pc_4        = in_data.pc_4;
        out_data.wb_data     = in_data.mem_r ? load_data : in_data.alu_res;
        out_data.reg_w       = in_data.reg_w;
        out_data.reg_byte_en = in_data.reg_byte_en;
        out_data.rd_addr     = in_data.rd_addr;
        out_data.taken       = in_data.jmp || (in_data.branch && cond_met);
        out_data.target      = in_data.target;
    end

    a_no_read_write: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |-> !(in_data.mem_r && in_data.mem_w)
    );

endmodule

/* src/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    data_valid,
    output logic                    data_ready,
    input  mem_stage_pkg::mem_req_t data_req,
    output logic                    data_rsp_valid,
    input  logic                    fetch_valid,
    output logic                    fetch_ready,
    input  mem_stage_pkg::mem_req_t fetch_req,
    output logic                    fetch_rsp_valid,
    output logic                    ram_valid,
    output mem_stage_pkg::mem_req_t ram_req,
    input  logic                    ram_rsp_valid
);

    logic grant_fetch;
    logic owner_fetch;

    // Data port wins and the RAM never stalls
    assign data_ready  = 1'b1;
    assign fetch_ready = !data_valid;
    assign grant_fetch = fetch_valid && !data_valid;

    assign ram_valid = data_valid || fetch_valid;
    assign ram_req   = data_valid ? data_req : fetch_req;

    // Owner of the access now in the RAM
    always_ff @(posedge clk) begin
        if (rst) begin
            owner_fetch <= 1'b0;
        end else begin
            owner_fetch <= grant_fetch;
        end
    end

    assign data_rsp_valid  = ram_rsp_valid && !owner_fetch;
    assign fetch_rsp_valid = ram_rsp_valid && owner_fetch;

    a_one_grant: assert property (
        @(posedge clk) disable iff (rst)
        (data_valid && fetch_valid) |-> !(data_ready && fetch_ready)
    );

endmodule

/* src/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
    parameter int ADDR_BITS = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  mem_stage_pkg::mem_req_t req,
    output logic                    rsp_valid,
    output logic [31:0]             rdata
);

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [31:0]          mem [DEPTH];
    logic [ADDR_BITS-1:0] idx;

    // Word index with the byte offset dropped
    assign idx = req.addr[ADDR_BITS+1:2];

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (req_valid && req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req.byte_en[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rdata <= mem[idx];
        end
    end

    // Every access, read or write, answers one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

endmodule

/* src/mem_stage_top.sv */
`timescale 1ns/1ps

module mem_stage_top #(
    parameter int ADDR_BITS = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          ex_valid,
    output logic                          ex_ready,
    input  mem_stage_pkg::exmem_payload_t ex_data,
    input  logic                          fetch_valid,
    output logic                          fetch_ready,
    input  mem_stage_pkg::mem_req_t       fetch_req,
    output logic                          fetch_rsp_valid,
    output logic [31:0]                   fetch_rsp_data,
    output logic                          wb_valid,
    output mem_stage_pkg::memwb_payload_t wb_data
);

    logic                          exmem_valid;
    logic                          exmem_ready;
    mem_stage_pkg::exmem_payload_t exmem_data;
    logic                          unit_valid;
    logic                          unit_ready;
    mem_stage_pkg::memwb_payload_t unit_data;
    logic                          dreq_valid;
    logic                          dreq_ready;
    mem_stage_pkg::mem_req_t       dreq;
    logic                          drsp_valid;
    logic                          ram_valid;
    mem_stage_pkg::mem_req_t       ram_req;
    logic                          ram_rsp_valid;
    logic [31:0]                   ram_rdata;

    ////////////////////////////////////////////////////////////
    // Pipeline path
    ////////////////////////////////////////////////////////////

    pipe_reg #(
        .payload_t (mem_stage_pkg::exmem_payload_t)
    ) exmem_reg_inst (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (ex_valid),
        .in_ready  (ex_ready),
        .in_data   (ex_data),
        .out_valid (exmem_valid),
        .out_ready (exmem_ready),
        .out_data  (exmem_data)
    );

    mem_stage_unit mem_stage_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (exmem_valid),
        .in_ready  (exmem_ready),
        .in_data   (exmem_data),
        .req_valid (dreq_valid),
        .req_ready (dreq_ready),
        .req       (dreq),
        .rsp_valid (drsp_valid),
        .rsp_data  (ram_rdata),
        .out_valid (unit_valid),
        .out_ready (unit_ready),
        .out_data  (unit_data)
    );

    // Writeback always accepts
    pipe_reg #(
        .payload_t (mem_stage_pkg::memwb_payload_t)
    ) memwb_reg_inst (
        .clk       (clk),
        .rst       (rst),
        .flush     (1'b0),
        .in_valid  (unit_valid),
        .in_ready  (unit_ready),
        .in_data   (unit_data),
        .out_valid (wb_valid),
        .out_ready (1'b1),
        .out_data  (wb_data)
    );

    ////////////////////////////////////////////////////////////
    // Shared RAM
    ////////////////////////////////////////////////////////////

    mem_arbiter mem_arbiter_inst (
        .clk             (clk),
        .rst             (rst),
        .data_valid      (dreq_valid),
        .data_ready      (dreq_ready),
        .data_req        (dreq),
        .data_rsp_valid  (drsp_valid),
        .fetch_valid     (fetch_valid),
        .fetch_ready     (fetch_ready),
        .fetch_req       (fetch_req),
        .fetch_rsp_valid (fetch_rsp_valid),
        .ram_valid       (ram_valid),
        .ram_req         (ram_req),
        .ram_rsp_valid   (ram_rsp_valid)
    );

    data_ram #(
        .ADDR_BITS (ADDR_BITS)
    ) data_ram_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (ram_valid),
        .req       (ram_req),
        .rsp_valid (ram_rsp_valid),
        .rdata     (ram_rdata)
    );

    // Read word shared by both requesters
    assign fetch_rsp_data = ram_rdata;

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Reset held for 16 rising edges
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* bench/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb;

    localparam int ADDR_BITS   = 8;
    localparam int TIMEOUT     = 200;
    localparam int FETCH_BASE  = 128;
    localparam int FETCH_WORDS = 16;
    localparam int MODE_PLAIN  = 0;
    localparam int MODE_DROP   = 1;
    localparam int MODE_STALL  = 2;

    logic                          clk;
    logic                          rst;
    logic                          flush;
    logic                          ex_valid;
    logic                          ex_ready;
    mem_stage_pkg::exmem_payload_t ex_data;
    logic                          fetch_valid;
    logic                          fetch_ready;
    mem_stage_pkg::mem_req_t       fetch_req;
    logic                          fetch_rsp_valid;
    logic [31:0]                   fetch_rsp_data;
    logic                          wb_valid;
    mem_stage_pkg::memwb_payload_t wb_data;

    // Stimulus table with expected records and flush mode per entry
    mem_stage_pkg::exmem_payload_t stim [$];
    mem_stage_pkg::memwb_payload_t expect_rec [$];
    int                            mode [$];
    mem_stage_pkg::memwb_payload_t wb_expect_q [$];
    logic [31:0]                   model_mem [1 << ADDR_BITS];

    integer seed           = 32'h24b518f5;
    int     fetch_start    = 0;
    int     mismatch_count = 0;
    int     timeout_count  = 0;
    int     other_count    = 0;
    int     wb_count       = 0;
    int     fetch_count    = 0;
    int     stall_flushes  = 0;
    logic   fetch_on;
    logic   fetch_busy;

    tb_clock tb_clock_inst (
        .clk (clk),
        .rst (rst)
    );

    mem_stage_top #(
        .ADDR_BITS (ADDR_BITS)
    ) mem_stage_top_inst (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .ex_valid        (ex_valid),
        .ex_ready        (ex_ready),
        .ex_data         (ex_data),
        .fetch_valid     (fetch_valid),
        .fetch_ready     (fetch_ready),
        .fetch_req       (fetch_req),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp_data  (fetch_rsp_data),
        .wb_valid        (wb_valid),
        .wb_data         (wb_data)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Pseudo-random contents keyed on the word index
    function automatic logic [31:0] fill_word(input int idx);
        logic [31:0] a;
        a = idx;
        return ((a + 32'd1) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] format_load(input logic [31:0] word,
                                                input logic [1:0] lane,
                                                input mem_stage_pkg::load_sel_e sel);
        logic [31:0] bv;
        logic [31:0] hv;
        bv = (word >> (8 * lane)) & 32'hff;
        hv = (word >> (16 * lane[1])) & 32'hffff;
        case (sel)
            mem_stage_pkg::LOAD_BYTE_S: return bv[7] ? bv - 32'h100 : bv;
            mem_stage_pkg::LOAD_BYTE_U: return bv;
            mem_stage_pkg::LOAD_HALF_S: return hv[15] ? hv - 32'h1_0000 : hv;
            mem_stage_pkg::LOAD_HALF_U: return hv;
            default:                    return word;
        endcase
    endfunction

    // zf is a == b, lf is a < b
    function automatic logic branch_taken(input mem_stage_pkg::exmem_payload_t e);
        logic met;
        case (e.condition)
            mem_stage_pkg::COND_EQ: met = e.zf;
            mem_stage_pkg::COND_NE: met = !e.zf;
            mem_stage_pkg::COND_LT: met = e.lf;
            mem_stage_pkg::COND_GE: met = !e.lf;
            mem_stage_pkg::COND_GT: met = !(e.lf || e.zf);
            mem_stage_pkg::COND_LE: met = e.lf || e.zf;
            default:                met = 1'b0;
        endcase
        return e.jmp || (e.branch && met);
    endfunction

    function automatic mem_stage_pkg::exmem_payload_t base_entry();
        mem_stage_pkg::exmem_payload_t e;
        e             = '0;
        e.pc_4        = {$random(seed)} & 32'hffff_fffc;
        e.alu_res     = $random(seed);
        e.reg_w       = $random(seed);
        e.reg_byte_en = $random(seed);
        e.rd_addr     = $random(seed);
        e.target      = $random(seed);
        e.lf          = $random(seed);
        e.zf          = $random(seed);
        e.condition   = mem_stage_pkg::cond_e'({$random(seed)} % 6);
        return e;
    endfunction

    function automatic mem_stage_pkg::exmem_payload_t mem_entry(input int word, input int lane,
                                                                input logic wr);
        mem_stage_pkg::exmem_payload_t e;
        e             = base_entry();
        e.alu_res     = (word << 2) | lane;
        e.mem_r       = !wr;
        e.mem_w       = wr;
        e.mem_byte_en = 4'hf;
        e.store_data  = $random(seed);
        return e;
    endfunction

    // Expected record from the model, then the store lands in the model
    task automatic add_entry(input mem_stage_pkg::exmem_payload_t e, input int m);
        mem_stage_pkg::memwb_payload_t r;
        int idx;
        idx           = e.alu_res[ADDR_BITS+1:2];
        r.pc_4        = e.pc_4;
        r.reg_w       = e.reg_w;
        r.reg_byte_en = e.reg_byte_en;
        r.rd_addr     = e.rd_addr;
        r.target      = e.target;
        r.taken       = branch_taken(e);
        if (e.mem_r) begin
            r.wb_data = format_load(model_mem[idx], e.alu_res[1:0], e.load_sel);
        end else begin
            r.wb_data = e.alu_res;
        end
        if (e.mem_w && m != MODE_DROP) begin
            for (int b = 0; b < 4; b++) begin
                if (e.mem_byte_en[b]) begin
                    model_mem[idx][8*b +: 8] = e.store_data[8*b +: 8];
                end
            end
        end
        stim.push_back(e);
        expect_rec.push_back(r);
        mode.push_back(m);
    endtask

    task automatic build_table();
        mem_stage_pkg::exmem_payload_t e;
        logic [3:0] be_list [8];
        int kind;
        be_list = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b0110, 4'b1111};

        e = base_entry();
        e.alu_res = 32'hcafe_0123;
        add_entry(e, MODE_PLAIN);

        // Known contents for the data window and the fetch window
        for (int w = 0; w < 16; w++) begin
            e = mem_entry(w, 0, 1'b1);
            e.store_data = fill_word(w);
            add_entry(e, MODE_PLAIN);
            e = mem_entry(FETCH_BASE + w, 0, 1'b1);
            e.store_data = fill_word(FETCH_BASE + w);
            add_entry(e, MODE_PLAIN);
        end
        fetch_start = stim.size();

        // Partial stores, then every load format on every lane
        for (int w = 0; w < 8; w++) begin
            e = mem_entry(w, 0, 1'b1);
            e.mem_byte_en = be_list[w];
            add_entry(e, MODE_PLAIN);
        end
        for (int w = 0; w < 8; w++) begin
            for (int s = 0; s < 5; s++) begin
                for (int l = 0; l < 4; l++) begin
                    e = mem_entry(w, l, 1'b0);
                    e.load_sel = mem_stage_pkg::load_sel_e'(s);
                    add_entry(e, MODE_PLAIN);
                end
            end
        end

        // Each condition against all flag pairs, then a plain jump
        for (int c = 0; c < 6; c++) begin
            for (int f = 0; f < 4; f++) begin
                e = base_entry();
                e.branch    = 1'b1;
                e.condition = mem_stage_pkg::cond_e'(c);
                e.lf        = f[1];
                e.zf        = f[0];
                add_entry(e, MODE_PLAIN);
            end
        end
        e = base_entry();
        e.jmp = 1'b1;
        add_entry(e, MODE_PLAIN);

        // Mixed traffic with flushes sprinkled in
        for (int i = 0; i < 48; i++) begin
            kind = {$random(seed)} % 3;
            if (kind == 2) begin
                e = base_entry();
            end else begin
                e = mem_entry({$random(seed)} % 16, {$random(seed)} % 4, kind == 0);
                e.mem_byte_en = {$random(seed)} % 15 + 1;
                e.load_sel    = mem_stage_pkg::load_sel_e'({$random(seed)} % 5);
            end
            if (i % 7 == 3) begin
                add_entry(e, MODE_DROP);
            end else if (i % 4 == 1) begin
                add_entry(e, MODE_STALL);
            end else begin
                add_entry(e, MODE_PLAIN);
            end
        end

        // A dropped store leaves word 5 alone
        add_entry(mem_entry(5, 0, 1'b1), MODE_DROP);
        add_entry(mem_entry(5, 0, 1'b0), MODE_PLAIN);
        add_entry(base_entry(), MODE_STALL);
        add_entry(mem_entry(6, 0, 1'b1), MODE_PLAIN);
        add_entry(mem_entry(6, 2, 1'b0), MODE_STALL);
        add_entry(base_entry(), MODE_DROP);
        add_entry(mem_entry(6, 1, 1'b0), MODE_PLAIN);
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_wb(input mem_stage_pkg::memwb_payload_t got,
                            input mem_stage_pkg::memwb_payload_t exp);
        check_word("wb_data.pc_4", got.pc_4, exp.pc_4);
        check_word("wb_data.wb_data", got.wb_data, exp.wb_data);
        check_word("wb_data.reg_w", got.reg_w, exp.reg_w);
        check_word("wb_data.reg_byte_en", got.reg_byte_en, exp.reg_byte_en);
        check_word("wb_data.rd_addr", got.rd_addr, exp.rd_addr);
        check_word("wb_data.taken", got.taken, exp.taken);
        check_word("wb_data.target", got.target, exp.target);
    endtask

    // Writeback records in entry order
    always @(negedge clk) begin
        if (!rst && wb_valid === 1'b1) begin
            if (wb_expect_q.size() == 0) begin
                $display("Writeback record with pc_4 0x%h arrived but none was expected",
                         wb_data.pc_4);
                other_count++;
            end else begin
                check_wb(wb_data, wb_expect_q.pop_front());
                wb_count++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////

    task automatic send_entry(input int i);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        ex_data  = stim[i];
        ex_valid = 1'b1;
        while (!accepted && waited < TIMEOUT) begin
            accepted = ex_ready;
            flush    = (mode[i] == MODE_DROP) || (mode[i] == MODE_STALL && !ex_ready);
            if (mode[i] == MODE_STALL && !ex_ready) begin
                stall_flushes++;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        if (!accepted) begin
            $display("Timeout: entry %0d was not accepted within %0d cycles", i, TIMEOUT);
            timeout_count++;
        end
        ex_valid = 1'b0;
        flush    = 1'b0;
    endtask

    task automatic drain_wb();
        int waited;
        waited = 0;
        while (wb_expect_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (wb_expect_q.size() != 0) begin
            $display("Timeout: %0d writeback records never arrived", wb_expect_q.size());
            timeout_count++;
            wb_expect_q.delete();
        end
    endtask

    // Fetch reads at random cycles from the fetch window
    initial begin
        int   waited;
        int   word;
        logic accepted;
        forever begin
            @(negedge clk);
            if (fetch_on && ({$random(seed)} % 4 != 0)) begin
                fetch_busy = 1'b1;
                word = FETCH_BASE + {$random(seed)} % FETCH_WORDS;
                @(posedge clk);
                #1;
                fetch_req.addr    = word << 2;
                fetch_req.wdata   = '0;
                fetch_req.byte_en = 4'hf;
                fetch_req.we      = 1'b0;
                fetch_valid       = 1'b1;
                accepted = 1'b0;
                waited   = 0;
                while (!accepted && waited < TIMEOUT) begin
                    accepted = fetch_ready;
                    @(posedge clk);
                    #1;
                    waited++;
                end
                fetch_valid = 1'b0;
                if (!accepted) begin
                    $display("Timeout: fetch read of word %0d was never granted", word);
                    timeout_count++;
                end else begin
                    @(negedge clk);
                    if (fetch_rsp_valid !== 1'b1) begin
                        $display("Fetch response for word %0d missing after its grant", word);
                        other_count++;
                    end else begin
                        check_word("fetch_rsp_data", fetch_rsp_data, model_mem[word]);
                        fetch_count++;
                    end
                end
                fetch_busy = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int waited;
        int errors;
        flush       = 1'b0;
        ex_valid    = 1'b0;
        ex_data     = '0;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        fetch_on    = 1'b0;
        fetch_busy  = 1'b0;
        build_table();

        waited = 0;
        while (rst !== 1'b0 && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset never released");
            timeout_count++;
        end
        check_word("wb_valid", wb_valid, 32'd0);
        check_word("fetch_rsp_valid", fetch_rsp_valid, 32'd0);

        for (int i = 0; i < stim.size(); i++) begin
            // Fetch window must be in the RAM before reads start
            if (i == fetch_start) begin
                drain_wb();
                fetch_on = 1'b1;
            end
            if (mode[i] != MODE_DROP) begin
                wb_expect_q.push_back(expect_rec[i]);
            end
            send_entry(i);
        end
        drain_wb();

        fetch_on = 1'b0;
        waited   = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (fetch_busy && waited < TIMEOUT);
        if (fetch_busy) begin
            $display("Timeout: fetch driver did not go idle");
            timeout_count++;
        end
        if (fetch_count == 0) begin
            $display("No fetch read completed during the run");
            other_count++;
        end
        if (stall_flushes == 0) begin
            $display("Flush was never raised while ex_ready was low");
            other_count++;
        end

        errors = mismatch_count + timeout_count + other_count;
        $display("Writebacks %0d, fetch reads %0d, mismatches %0d, timeouts %0d, other %0d",
                 wb_count, fetch_count, mismatch_count, timeout_count, other_count);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tb.f */
src/mem_stage_pkg.sv
src/pipe_reg.sv
src/mem_stage_unit.sv
src/mem_arbiter.sv
src/data_ram.sv
src/mem_stage_top.sv
bench/tb_clock.sv
bench/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - src/mem_stage_pkg.sv
  - src/pipe_reg.sv
  - src/mem_stage_unit.sv
  - src/mem_arbiter.sv
  - src/data_ram.sv
  - src/mem_stage_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/mem_stage_tb.sv
